//--- Makefile
# Verilator build and run of the CSR unit testbench

VERILATOR ?= verilator
TOP       ?= csr_unit_tb
FILELIST  ?= csr_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

PASS_MSG := Testbench passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check the log for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- csr_unit.f
verilog/core_cfg_pkg.sv
verilog/csr_isa_pkg.sv
verilog/csr_dispatch.sv
verilog/csr_issue_fifo.sv
verilog/csr_exe.sv
verilog/csr_file.sv
verilog/phys_regfile.sv
verilog/csr_unit_top.sv
verification/tb_clock.sv
verification/csr_unit_chk.sv
verification/csr_unit_tb.sv

//--- verification/csr_unit_chk.sv
`default_nettype none

module csr_unit_chk
	import core_cfg_pkg::*;
	import csr_isa_pkg::*;
(
	input logic              CLK,
	input logic              rst_n,
	input logic              flush,
	input logic              hold,
	input logic              head_valid,
	input logic              wb_valid,
	input logic              csr_wen,
	input logic [1:0]        op_raw,
	input logic              is_imm,
	input logic [preg_w-1:0] src_tag,
	input logic              push,
	input logic              full
);

	timeunit 1ns;
	timeprecision 1ps;

	// Failure count, read by the testbench at the end of the run
	int fails = 0;

	// Head instruction leaves the FIFO in this cycle
	logic issue_now;
	// Zicsr zero source, uimm of 0 or rs1 of x0
	logic zero_src;

	assign issue_now = head_valid && !hold && !flush;
	assign zero_src  = is_imm ? (src_tag[arch_w-1:0] == '0) : (src_tag[preg_w-1:rb] == '0);

	// --------------------------------------------------
	// Writeback stage
	// --------------------------------------------------

	// Reset edge leaves the writeback stage empty
	a_wb_low_after_reset: assert property (@(posedge CLK) !rst_n |=> !wb_valid)
		else begin
			$error("wb_valid high in the cycle after reset");
			fails = fails + 1;
		end

	// Executed head shows up as wb_valid exactly one cycle later
	a_wb_after_issue: assert property (@(posedge CLK) disable iff (!rst_n)
		issue_now |=> wb_valid)
		else begin
			$error("executed instruction not followed by wb_valid");
			fails = fails + 1;
		end

	// Empty, stalled or flushed cycle leaves writeback quiet
	a_no_stray_wb: assert property (@(posedge CLK) disable iff (!rst_n)
		!issue_now |=> !wb_valid)
		else begin
			$error("wb_valid without an executed instruction");
			fails = fails + 1;
		end

	// --------------------------------------------------
	// CSR write and FIFO rules
	// --------------------------------------------------

	// Set or clear with a zero source never writes
	a_no_empty_write: assert property (@(posedge CLK) disable iff (!rst_n)
		csr_wen && op_raw != csr_rw |-> !zero_src)
		else begin
			$error("csr_wen for set or clear with zero operand");
			fails = fails + 1;
		end

	a_no_push_full: assert property (@(posedge CLK) disable iff (!rst_n) !(push && full))
		else begin
			$error("push while the FIFO is full");
			fails = fails + 1;
		end

endmodule

`default_nettype wire

//--- verification/csr_unit_tb.sv
`default_nettype none

module csr_unit_tb
	import core_cfg_pkg::*;
	import csr_isa_pkg::*;
;

	timeunit 1ns;
	timeprecision 1ps;

	// Expected writeback plus what it commits
	typedef struct {
		logic [xlen-1:0]   result;
		logic [preg_w-1:0] tag;
		logic [arch_w-1:0] rd;
		int                idx;
		logic [xlen-1:0]   csr_new;
		bit                wrote;
	} exp_t;

	logic CLK;
	logic rst_n;
	logic instr_strobe;
	csr_op_t instr_op;
	logic [arch_w-1:0] instr_rd;
	logic [arch_w-1:0] instr_rs1_or_imm;
	logic instr_is_imm;
	logic [11:0] instr_csr_addr;
	logic hold;
	logic flush;
	logic dispatch_full;
	logic wb_valid;
	logic [xlen-1:0] wb_result;
	logic [preg_w-1:0] wb_rd;

	// Model state, speculative and committed copies
	logic [xlen-1:0] spec_csr [6];
	logic [xlen-1:0] com_csr [6];
	logic [xlen-1:0] spec_reg [arch_regs];
	logic [xlen-1:0] com_reg [arch_regs];
	logic [rb-1:0]   spec_ver [arch_regs];
	logic [rb-1:0]   com_ver [arch_regs];
	exp_t            q [$];

	logic [11:0] addrs [6] = '{addr_mscratch, addr_mtvec, addr_mepc, addr_mcause, addr_mie, 12'h7c0};
	int seed = 32'hdc12;
	int errors = 0;
	int timeouts = 0;
	int afails;

	tb_clock u_clk (.CLK(CLK));

	csr_unit_top u_dut (.*);

	bind csr_exe csr_unit_chk u_chk (
		.CLK(CLK), .rst_n(rst_n), .flush(flush), .hold(hold), .head_valid(head_valid),
		.wb_valid(wb_valid), .csr_wen(csr_wen), .op_raw(op_raw), .is_imm(is_imm),
		.src_tag(src), .push(1'b0), .full(1'b0)
	);
	bind csr_issue_fifo csr_unit_chk u_chk (
		.CLK(CLK), .rst_n(rst_n), .flush(1'b0), .hold(1'b0), .head_valid(1'b0),
		.wb_valid(1'b0), .csr_wen(1'b0), .op_raw(2'd0), .is_imm(1'b0),
		.src_tag('0), .push(push), .full(full)
	);

	// --------------------------------------------------
	// Reference model
	// --------------------------------------------------

	// Slot 5 stands for any unimplemented address
	function automatic int csr_index(logic [11:0] addr);
		for (int i = 0; i < 5; i++)
			if (addrs[i] == addr)
				return i;
		return 5;
	endfunction

	function automatic logic [arch_w-1:0] rnd5();
		return arch_w'($random(seed));
	endfunction

	// Strobe one instruction after the full level allows it
	task automatic issue(csr_op_t op, int rd, int rs, bit imm, logic [11:0] addr);
		exp_t e;
		logic [xlen-1:0] opnd;
		int n;
		n = 0;
		@(negedge CLK);
		while (dispatch_full && n < 50) begin
			n++;
			@(negedge CLK);
		end
		if (dispatch_full) begin
			$display("Timeout waiting for dispatch_full to drop");
			timeouts++;
		end
		@(posedge CLK);
		instr_strobe <= 1'b1;
		instr_op <= op;
		instr_rd <= arch_w'(rd);
		instr_rs1_or_imm <= arch_w'(rs);
		instr_is_imm <= imm;
		instr_csr_addr <= addr;
		// Program-order execution in the model
		e.idx = csr_index(addr);
		e.result = (e.idx < 5) ? spec_csr[e.idx] : '0;
		opnd = imm ? xlen'(rs) : spec_reg[rs];
		case (op)
			csr_rw: e.csr_new = opnd;
			csr_rs: e.csr_new = e.result | opnd;
			default: e.csr_new = e.result & ~opnd;
		endcase
		e.wrote = (op == csr_rw) || (opnd != '0);
		if (e.wrote && e.idx < 5)
			spec_csr[e.idx] = e.csr_new;
		e.rd = arch_w'(rd);
		e.tag = '0;
		if (rd != 0) begin
			spec_ver[rd] = spec_ver[rd] + 1'b1;
			spec_reg[rd] = e.result;
			e.tag = {e.rd, spec_ver[rd]};
		end
		q.push_back(e);
		@(posedge CLK);
		instr_strobe <= 1'b0;
	endtask

	task automatic drain();
		int n;
		n = 0;
		while (q.size() != 0 && n < 200) begin
			n++;
			@(negedge CLK);
		end
		if (q.size() != 0) begin
			$display("Timeout waiting for %0d pending writebacks", q.size());
			timeouts++;
			q.delete();
		end
	endtask

	// Writeback monitor, sampled mid-cycle
	always @(negedge CLK) begin
		exp_t e;
		if (rst_n && wb_valid) begin
			if (q.size() == 0) begin
				$display("Writeback arrived with nothing pending");
				errors++;
			end else begin
				e = q.pop_front();
				assert (wb_result == e.result) else begin
					$display("CHECK FAILED wb_result got %h expected %h", wb_result, e.result);
					errors++;
				end
				assert (wb_rd == e.tag) else begin
					$display("CHECK FAILED wb_rd got %h expected %h", wb_rd, e.tag);
					errors++;
				end
				// Commit what this writeback retires
				if (e.wrote && e.idx < 5)
					com_csr[e.idx] = e.csr_new;
				if (e.rd != '0) begin
					com_reg[e.rd] = e.result;
					com_ver[e.rd] = e.tag[rb-1:0];
				end
			end
		end
	end

	// --------------------------------------------------
	// Stimulus
	// --------------------------------------------------
	initial begin
		rst_n = 1'b0;
		instr_strobe = 1'b0;
		instr_op = csr_rw;
		instr_rd = '0;
		instr_rs1_or_imm = '0;
		instr_is_imm = 1'b0;
		instr_csr_addr = '0;
		hold = 1'b0;
		flush = 1'b0;
		spec_csr = '{default: '0};
		com_csr = '{default: '0};
		spec_reg = '{default: '0};
		com_reg = '{default: '0};
		spec_ver = '{default: '0};
		com_ver = '{default: '0};
		repeat (5) @(posedge CLK);
		rst_n <= 1'b1;

		// rw with immediate, then a plain read, on every address
		for (int i = 0; i < 6; i++) begin
			issue(csr_rw, 1, rnd5(), 1, addrs[i]);
			issue(csr_rs, 2, 0, 1, addrs[i]);
		end
		drain();

		// Set and clear, both sources, zero operands included
		for (int r = 0; r < 4; r++) begin
			issue(csr_rw, 0, rnd5(), 1, addr_mscratch);
			issue(csr_rs, 3, 0, 1, addr_mscratch);
			issue(csr_rs, 7, 3, 0, addr_mtvec);
			issue(csr_rc, 8, rnd5(), 1, addr_mtvec);
			issue(csr_rc, 9, 0, 0, addr_mepc);
			issue(csr_rs, 10, 0, 1, addr_mcause);
			issue(csr_rc, 11, 3, 0, addr_mie);
			issue(csr_rs, 12, 0, 1, addr_mtvec);
		end
		drain();

		// Dependent pair queued under hold, so they execute back to back
		@(posedge CLK) hold <= 1'b1;
		issue(csr_rs, 4, 0, 1, addr_mscratch);
		issue(csr_rw, 6, 4, 0, addr_mepc);
		issue(csr_rs, 13, 6, 0, addr_mie);
		@(posedge CLK) hold <= 1'b0;
		drain();

		// Fill the FIFO, the fifth strobe waits for room
		@(posedge CLK) hold <= 1'b1;
		for (int i = 0; i < 4; i++)
			issue(csr_rs, 14 + i, i + 1, 1, addr_mie);
		@(negedge CLK);
		assert (dispatch_full) else begin
			$display("CHECK FAILED dispatch_full got %h expected 1", dispatch_full);
			errors++;
		end
		fork
			issue(csr_rw, 18, 5'h15, 1, addr_mie);
			begin
				repeat (3) @(posedge CLK);
				hold <= 1'b0;
			end
		join
		drain();

		// Queued work killed by flush
		@(posedge CLK) hold <= 1'b1;
		issue(csr_rw, 5, rnd5(), 1, addr_mepc);
		issue(csr_rs, 6, 5, 0, addr_mscratch);
		@(posedge CLK) flush <= 1'b1;
		@(posedge CLK);
		flush <= 1'b0;
		hold <= 1'b0;
		q.delete();
		spec_csr = com_csr;
		spec_reg = com_reg;
		spec_ver = com_ver;
		// Monitor flags any writeback in this window
		repeat (6) @(posedge CLK);
		// Killed rd registers renamed again, their tags expose the rollback
		issue(csr_rs, 5, 0, 1, addr_mscratch);
		// Committed x6 copied into mepc and read back
		issue(csr_rw, 6, 6, 0, addr_mepc);
		issue(csr_rs, 21, 0, 1, addr_mepc);
		drain();
		repeat (3) @(posedge CLK);

		afails = u_dut.u_exe.u_chk.fails + u_dut.u_fifo.u_chk.fails;
		$display("errors=%0d timeouts=%0d assertion_failures=%0d", errors, timeouts, afails);
		if (errors == 0 && timeouts == 0 && afails == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/tb_clock.sv
`default_nettype none

module tb_clock (
	output logic CLK
);

	timeunit 1ns;
	timeprecision 1ps;

	// Free-running clock, 100 ns period
	initial CLK = 1'b0;
	always #50 CLK = ~CLK;

endmodule

`default_nettype wire

//--- verilog/core_cfg_pkg.sv
`default_nettype none

package core_cfg_pkg;

	// --------------------------------------------------
	// Datapath and rename sizes
	// --------------------------------------------------

	// Integer register and CSR width
	localparam int xlen = 64;

	// Architectural register index width and count
	localparam int arch_w    = 5;
	localparam int arch_regs = 32;

	// Version bits per architectural register
	localparam int rb = 2;

	// Physical tag is {arch index, version}
	localparam int preg_w = arch_w + rb;
	localparam int nregs  = 2 ** preg_w;

	// Issue buffer depth and its pointer width
	localparam int fifo_depth = 4;
	localparam int fifo_ptr_w = $clog2(fifo_depth);

endpackage

`default_nettype wire

//--- verilog/csr_dispatch.sv
`default_nettype none

module csr_dispatch
	import core_cfg_pkg::*;
	import csr_isa_pkg::*;
(
	input  logic               CLK,
	input  logic               rst_n,
	input  logic               flush,
	input  logic               instr_strobe,
	input  csr_op_t            instr_op,
	input  logic [arch_w-1:0]  instr_rd,
	input  logic [arch_w-1:0]  instr_rs1_or_imm,
	input  logic               instr_is_imm,
	input  logic [11:0]        instr_csr_addr,
	input  logic               wb_valid,
	input  logic [preg_w-1:0]  wb_rd,
	output logic               push,
	output logic [issue_w-1:0] issue_word
);

	// Version maps, one entry per architectural register
	logic [rb-1:0] spec_map   [arch_regs];
	logic [rb-1:0] commit_map [arch_regs];
	logic [rb-1:0] commit_nxt [arch_regs];

	logic [rb-1:0]     rd_ver;
	logic [preg_w-1:0] rd_tag;
	csr_src_u          src;

	// An instruction strobed together with flush is lost
	assign push = instr_strobe & ~flush;

	// x0 stays at version 0 forever
	assign rd_ver = (instr_rd == '0) ? '0 : spec_map[instr_rd] + rb'(1);
	assign rd_tag = {instr_rd, rd_ver};

	always_comb begin
		src = '0;
		if (instr_is_imm) begin
			src.imm.pad  = '0;
			src.imm.uimm = instr_rs1_or_imm;
		end else begin
			// rs1 reads whatever version is newest in flight
			src.tag = {instr_rs1_or_imm, spec_map[instr_rs1_or_imm]};
		end
	end

	assign issue_word = {instr_op, rd_tag, src, instr_is_imm, instr_csr_addr};

	// --------------------------------------------------
	// Committed map follows writeback
	// --------------------------------------------------
	always_comb begin
		commit_nxt = commit_map;
		if (wb_valid && wb_rd[preg_w-1:rb] != '0)
			commit_nxt[wb_rd[preg_w-1:rb]] = wb_rd[rb-1:0];
	end

	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			spec_map   <= '{default: '0};
			commit_map <= '{default: '0};
		end else begin
			commit_map <= commit_nxt;
			// Rollback includes a writeback landing in the same cycle
			if (flush)
				spec_map <= commit_nxt;
			else if (push && instr_rd != '0)
				spec_map[instr_rd] <= rd_ver;
		end
	end

endmodule

`default_nettype wire

//--- verilog/csr_exe.sv
`default_nettype none

module csr_exe
	import core_cfg_pkg::*;
	import csr_isa_pkg::*;
(
	input  logic               CLK,
	input  logic               rst_n,
	input  logic               flush,
	input  logic               hold,
	input  logic               head_valid,
	input  logic [issue_w-1:0] head_word,
	output logic               pop,
	output logic [11:0]        csr_addr,
	output logic               csr_wen,
	output logic [xlen-1:0]    csr_wdata,
	input  logic [xlen-1:0]    csr_rdata,
	output logic [preg_w-1:0]  rd_tag,
	input  logic [xlen-1:0]    rd_data,
	output logic               wb_valid,
	output logic [xlen-1:0]    wb_result,
	output logic [preg_w-1:0]  wb_rd
);

	// --------------------------------------------------
	// Issue word decode
	// --------------------------------------------------
	logic [1:0]        op_raw;
	csr_op_t           op;
	logic [preg_w-1:0] dst_tag;
	csr_src_u          src;
	logic              is_imm;

	logic [xlen-1:0] operand;
	logic            bypass_hit;
	logic            skip_write;

	assign {op_raw, dst_tag, src, is_imm, csr_addr} = head_word;
	assign op = csr_op_t'(op_raw);

	// Register port always looks at the tag view of src
	assign rd_tag = src.tag;

	// Execute when the head is there, no stall and no flush in progress
	assign pop = head_valid & ~hold & ~flush;

	// Result in writeback is not yet in the register file
	// x0 tags never bypass, they must read as zero
	assign bypass_hit = wb_valid && (wb_rd == src.tag) && (src.tag[preg_w-1:rb] != '0);

	always_comb begin
		if (is_imm)
			operand = {{(xlen-arch_w){1'b0}}, src.imm.uimm};
		else if (bypass_hit)
			operand = wb_result;
		else
			operand = rd_data;
	end

	// --------------------------------------------------
	// CSR write value
	// --------------------------------------------------
	always_comb begin
		case (op)
			csr_rw:  csr_wdata = operand;
			csr_rs:  csr_wdata = csr_rdata | operand;
			csr_rc:  csr_wdata = csr_rdata & ~operand;
			// Unused encoding rewrites the old value
			default: csr_wdata = csr_rdata;
		endcase
	end

	// Set or clear with nothing to change does not write
	assign skip_write = (op != csr_rw) && (operand == '0);
	assign csr_wen    = pop & ~skip_write;

	// --------------------------------------------------
	// Writeback stage
	// --------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!rst_n || flush)
			wb_valid <= 1'b0;
		else
			wb_valid <= pop;
	end

	// Old CSR value goes to rd
	always_ff @(posedge CLK) begin
		if (pop) begin
			wb_result <= csr_rdata;
			wb_rd     <= dst_tag;
		end
	end

endmodule

`default_nettype wire

//--- verilog/csr_file.sv
`default_nettype none

module csr_file
	import core_cfg_pkg::*;
	import csr_isa_pkg::*;
(
	input  logic            CLK,
	input  logic            rst_n,
	input  logic [11:0]     csr_addr,
	input  logic            csr_wen,
	input  logic [xlen-1:0] csr_wdata,
	output logic [xlen-1:0] csr_rdata
);

	// --------------------------------------------------
	// Machine-mode registers
	// --------------------------------------------------
	logic [xlen-1:0] mscratch;
	logic [xlen-1:0] mtvec;
	logic [xlen-1:0] mepc;
	logic [xlen-1:0] mcause;
	logic [xlen-1:0] mie;

	// Read port is a plain address decode
	always_comb begin
		case (csr_addr)
			addr_mscratch: csr_rdata = mscratch;
			addr_mtvec:    csr_rdata = mtvec;
			addr_mepc:     csr_rdata = mepc;
			addr_mcause:   csr_rdata = mcause;
			addr_mie:      csr_rdata = mie;
			// Anything else reads as zero
			default:       csr_rdata = '0;
		endcase
	end

	// --------------------------------------------------
	// Write port
	// --------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!rst_n) begin
			mscratch <= '0;
			mtvec    <= '0;
			mepc     <= '0;
			mcause   <= '0;
			mie      <= '0;
		end else if (csr_wen) begin
			// Unknown address drops the write
			case (csr_addr)
				addr_mscratch: mscratch <= csr_wdata;
				addr_mtvec:    mtvec    <= csr_wdata;
				addr_mepc:     mepc     <= csr_wdata;
				addr_mcause:   mcause   <= csr_wdata;
				addr_mie:      mie      <= csr_wdata;
				default: begin
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/csr_isa_pkg.sv
`default_nettype none

package csr_isa_pkg;

	import core_cfg_pkg::*;

	// --------------------------------------------------
	// Zicsr operation kinds
	// --------------------------------------------------

	// Register and immediate forms share a kind, is_imm tells them apart
	typedef enum logic [1:0] {
		csr_rw = 2'd0,
		csr_rs = 2'd1,
		csr_rc = 2'd2
	} csr_op_t;

	// Machine-mode CSR addresses that exist in this core
	localparam logic [11:0] addr_mie      = 12'h304;
	localparam logic [11:0] addr_mtvec    = 12'h305;
	localparam logic [11:0] addr_mscratch = 12'h340;
	localparam logic [11:0] addr_mepc     = 12'h341;
	localparam logic [11:0] addr_mcause   = 12'h342;

	// --------------------------------------------------
	// Source operand field
	// --------------------------------------------------

	// Same bits are either a renamed rs1 tag or a zero-padded uimm
	typedef union packed {
		logic [preg_w-1:0] tag;
		struct packed {
			logic [preg_w-arch_w-1:0] pad;
			logic [arch_w-1:0]        uimm;
		} imm;
	} csr_src_u;

	// Issue word is {op, rd tag, src, is_imm, csr address}
	localparam int issue_w = 2 + preg_w + preg_w + 1 + 12;

endpackage

`default_nettype wire

//--- verilog/csr_issue_fifo.sv
`default_nettype none

module csr_issue_fifo
	import core_cfg_pkg::*;
	import csr_isa_pkg::*;
(
	input  logic               CLK,
	input  logic               rst_n,
	input  logic               flush,
	input  logic               push,
	input  logic [issue_w-1:0] issue_word,
	input  logic               pop,
	output logic               head_valid,
	output logic [issue_w-1:0] head_word,
	output logic               full
);

	// --------------------------------------------------
	// Storage and pointers
	// --------------------------------------------------
	logic [issue_w-1:0]    mem [fifo_depth];
	logic [fifo_ptr_w-1:0] wr_ptr;
	logic [fifo_ptr_w-1:0] rd_ptr;
	logic [fifo_ptr_w:0]   count;

	logic do_push;
	logic do_pop;

	// Full status comes straight from the occupancy count
	assign full       = (count == (fifo_ptr_w + 1)'(fifo_depth));
	assign head_valid = (count != '0);

	// First-word fall-through, head is visible with no read latency
	assign head_word = mem[rd_ptr];

	// Push into a full buffer is dropped
	assign do_push = push & ~full;
	assign do_pop  = pop & head_valid;

	// Entries hold payload only
	always_ff @(posedge CLK) begin
		if (do_push)
			mem[wr_ptr] <= issue_word;
	end

	// --------------------------------------------------
	// Pointer and count update
	// --------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!rst_n || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			// Pointers wrap naturally at the power-of-two depth
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Simultaneous push and pop keeps the count
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/csr_unit_top.sv
`default_nettype none

module csr_unit_top
	import core_cfg_pkg::*;
	import csr_isa_pkg::*;
(
	input  logic              CLK,
	input  logic              rst_n,
	input  logic              instr_strobe,
	input  csr_op_t           instr_op,
	input  logic [arch_w-1:0] instr_rd,
	input  logic [arch_w-1:0] instr_rs1_or_imm,
	input  logic              instr_is_imm,
	input  logic [11:0]       instr_csr_addr,
	input  logic              hold,
	input  logic              flush,
	output logic              dispatch_full,
	output logic              wb_valid,
	output logic [xlen-1:0]   wb_result,
	output logic [preg_w-1:0] wb_rd
);

	// --------------------------------------------------
	// Internal nets
	// --------------------------------------------------
	logic               push;
	logic [issue_w-1:0] issue_word;
	logic               pop;
	logic               head_valid;
	logic [issue_w-1:0] head_word;

	logic [11:0]       csr_addr;
	logic              csr_wen;
	logic [xlen-1:0]   csr_wdata;
	logic [xlen-1:0]   csr_rdata;
	logic [preg_w-1:0] rd_tag;
	logic [xlen-1:0]   rd_data;

	// Rename and pack
	csr_dispatch u_dispatch (
		.CLK              (CLK),
		.rst_n            (rst_n),
		.flush            (flush),
		.instr_strobe     (instr_strobe),
		.instr_op         (instr_op),
		.instr_rd         (instr_rd),
		.instr_rs1_or_imm (instr_rs1_or_imm),
		.instr_is_imm     (instr_is_imm),
		.instr_csr_addr   (instr_csr_addr),
		.wb_valid         (wb_valid),
		.wb_rd            (wb_rd),
		.push             (push),
		.issue_word       (issue_word)
	);

	// Full level goes straight back to the source
	csr_issue_fifo u_fifo (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.flush      (flush),
		.push       (push),
		.issue_word (issue_word),
		.pop        (pop),
		.head_valid (head_valid),
		.head_word  (head_word),
		.full       (dispatch_full)
	);

	csr_exe u_exe (
		.CLK        (CLK),
		.rst_n      (rst_n),
		.flush      (flush),
		.hold       (hold),
		.head_valid (head_valid),
		.head_word  (head_word),
		.pop        (pop),
		.csr_addr   (csr_addr),
		.csr_wen    (csr_wen),
		.csr_wdata  (csr_wdata),
		.csr_rdata  (csr_rdata),
		.rd_tag     (rd_tag),
		.rd_data    (rd_data),
		.wb_valid   (wb_valid),
		.wb_result  (wb_result),
		.wb_rd      (wb_rd)
	);

	csr_file u_csr_file (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.csr_addr  (csr_addr),
		.csr_wen   (csr_wen),
		.csr_wdata (csr_wdata),
		.csr_rdata (csr_rdata)
	);

	// Writeback lands here one cycle after execute
	phys_regfile u_regfile (
		.CLK       (CLK),
		.rst_n     (rst_n),
		.rd_tag    (rd_tag),
		.rd_data   (rd_data),
		.wb_valid  (wb_valid),
		.wb_rd     (wb_rd),
		.wb_result (wb_result)
	);

endmodule

`default_nettype wire

//--- verilog/phys_regfile.sv
`default_nettype none

module phys_regfile
	import core_cfg_pkg::*;
(
	input  logic              CLK,
	input  logic              rst_n,
	input  logic [preg_w-1:0] rd_tag,
	output logic [xlen-1:0]   rd_data,
	input  logic              wb_valid,
	input  logic [preg_w-1:0] wb_rd,
	input  logic [xlen-1:0]   wb_result
);

	// One entry per {arch index, version} pair
	logic [xlen-1:0] regs [nregs];

	logic wr_en;

	// All versions of x0 stay zero
	assign wr_en = wb_valid && (wb_rd[preg_w-1:rb] != '0);

	// Combinational read port
	assign rd_data = regs[rd_tag];

	// --------------------------------------------------
	// Write port
	// --------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!rst_n)
			regs <= '{default: '0};
		else if (wr_en)
			regs[wb_rd] <= wb_result;
	end

endmodule

`default_nettype wire
